// File: common/adc5g_defs.svh
// timing and register constants; the bit period must stay a power of two for the 5-bit counter
`ifndef ADC5G_DEFS_SVH
`define ADC5G_DEFS_SVH

// OPB_Clk cycles per serial bit
`define ADC5G_BIT_PERIOD 32

// bit-counter value where the last bit of a transfer is done
`define ADC5G_MIDHIGH 5'd24

// ADC reset pulse length in OPB_Clk cycles
`define ADC5G_RST_LEN 8'd16

// sample point after reset, counted in OPB_Clk cycles into the bit
`define ADC5G_SAMPLE_INIT 5'd13

// word indices, taken from address bits 3:2
`define ADC5G_REG_CTRL   2'd0
`define ADC5G_REG_SPI    2'd1
`define ADC5G_REG_SAMPLE 2'd2
`define ADC5G_REG_DCM    2'd3

`endif

// File: common/adc5g_wb_pkg.sv
// bus-side types for a 32-bit Wishbone classic slave, little-endian byte selects
`default_nettype none

package adc5g_wb_pkg;

  typedef logic [31:0] wb_data_t;

  typedef logic [3:0] wb_sel_t;  // one bit per byte lane

  typedef logic [1:0] reg_idx_t;  // adr[3:2]

  // host request, sampled by the slave every cycle
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    wb_data_t    dat;
    wb_sel_t     sel;
  } wb_req_t;

endpackage

`default_nettype wire

// File: common/adc5g_spi_pkg.sv
// serial-side types for the ADC 3-wire port; one bit period spans the full counter range
`default_nettype none

`include "adc5g_defs.svh"

package adc5g_spi_pkg;

  typedef logic [7:0] spi_addr_t;  // bit 7 set means write

  typedef logic [15:0] spi_data_t;

  typedef logic [$clog2(`ADC5G_BIT_PERIOD)-1:0] bit_time_t;

  // shifted out MSB first, address ahead of data
  typedef struct packed {
    spi_addr_t addr;
    spi_data_t data;
  } spi_cmd_t;

  typedef struct packed {
    logic sclk;
    logic sdata;
    logic modepin;  // low while the ADC port is selected
  } spi_pins_t;

  typedef enum logic [2:0] {
    st_idle,
    st_clk_wait,
    st_addr,
    st_write,
    st_read_wait,
    st_read,
    st_almost_done,
    st_finish
  } spi_state_t;

endpackage

`default_nettype wire

// File: design/adc5g_wb_regs.sv
// four-word map at base 0, adr bits above 3:2 ignored; SPI word accesses stall while the engine is busy
`timescale 1ns/1ns
`default_nettype none

`include "adc5g_defs.svh"

module adc5g_wb_regs (
  input  wire logic                     OPB_Clk,
  input  wire logic                     rst_n,
  input  wire adc5g_wb_pkg::wb_req_t    wb_req,
  input  wire logic                     spi_idle,
  input  wire adc5g_spi_pkg::spi_data_t spi_rdata,
  input  wire logic                     adc_reset,
  input  wire logic                     dcm_locked,
  input  wire logic [15:0]              unlocked_cnt,
  output adc5g_wb_pkg::wb_data_t        wb_dat_o,
  output logic                          wb_ack,
  output adc5g_spi_pkg::spi_cmd_t       spi_cmd,
  output logic                          spi_start,
  output adc5g_spi_pkg::bit_time_t      sample_time,
  output logic                          rst_req
);
  import adc5g_wb_pkg::*;

  reg_idx_t idx;
  logic     req;
  logic     spi_busy_hit;
  logic     accept;
  wb_data_t rd_word;
  wb_data_t rd_q;

  assign idx          = wb_req.adr[3:2];
  assign req          = wb_req.cyc && wb_req.stb && !wb_ack;  // no retrigger in the ack cycle
  assign spi_busy_hit = (idx == `ADC5G_REG_SPI) && !spi_idle;
  assign accept       = req && !spi_busy_hit;

  // readback word for the addressed register
  always_comb begin
    rd_word = '0;
    case (idx)
      `ADC5G_REG_CTRL: begin
        rd_word[0] = adc_reset;
      end
      `ADC5G_REG_SPI: begin
        rd_word = {spi_rdata, spi_cmd.addr, 7'b0, spi_idle};
      end
      `ADC5G_REG_SAMPLE: begin
        rd_word[4:0] = sample_time;
      end
      `ADC5G_REG_DCM: begin
        rd_word = {15'b0, dcm_locked, unlocked_cnt};
      end
      default: begin
        rd_word = '0;
      end
    endcase
  end

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      wb_ack      <= 1'b0;
      spi_start   <= 1'b0;
      rst_req     <= 1'b0;
      spi_cmd     <= '0;
      sample_time <= `ADC5G_SAMPLE_INIT;
    end else begin
      wb_ack    <= accept;
      spi_start <= 1'b0;  // pulses
      rst_req   <= 1'b0;
      if (accept && wb_req.we) begin
        case (idx)
          `ADC5G_REG_CTRL: begin
            rst_req <= wb_req.sel[0] && wb_req.dat[0];
          end
          `ADC5G_REG_SPI: begin
            if (wb_req.sel[3]) begin
              spi_cmd.data[15:8] <= wb_req.dat[31:24];
            end
            if (wb_req.sel[2]) begin
              spi_cmd.data[7:0] <= wb_req.dat[23:16];
            end
            if (wb_req.sel[1]) begin
              spi_cmd.addr <= wb_req.dat[15:8];
            end
            spi_start <= wb_req.sel[0] && wb_req.dat[0];  // engine loads the new cmd
          end
          `ADC5G_REG_SAMPLE: begin
            if (wb_req.sel[0]) begin
              sample_time <= wb_req.dat[4:0];
            end
          end
          default: begin
            // DCM word is read only, write just gets acked
          end
        endcase
      end
    end
  end

  // captured with the request, shown during ack only
  always_ff @(posedge OPB_Clk) begin
    if (accept) begin
      rd_q <= rd_word;
    end
  end

  assign wb_dat_o = wb_ack ? rd_q : '0;

endmodule

`default_nettype wire

// File: spi/adc5g_spi_master.sv
// one transfer at a time; writes are 24 bits, reads are 8 address bits then 16 sampled data bits
`timescale 1ns/1ns
`default_nettype none

`include "adc5g_defs.svh"

module adc5g_spi_master (
  input  wire logic                     OPB_Clk,
  input  wire logic                     rst_n,
  input  wire adc5g_spi_pkg::spi_cmd_t  cmd,
  input  wire logic                     start,
  input  wire adc5g_spi_pkg::bit_time_t sample_time,
  input  wire logic                     sdo,
  output adc5g_spi_pkg::spi_pins_t      pins,
  output logic                          idle,
  output adc5g_spi_pkg::spi_data_t      rdata
);
  import adc5g_spi_pkg::*;

  localparam logic [4:0] addr_last  = 5'd7;   // last address bit
  localparam logic [4:0] write_last = 5'd23;  // last bit of a write
  localparam logic [4:0] read_end   = 5'd24;  // all 16 read bits in

  spi_state_t                  state;
  bit_time_t                   bit_cnt;
  logic [4:0]                  bit_idx;
  logic                        writing;
  logic [$bits(spi_cmd_t)-1:0] tx_shift;
  spi_data_t                   rx_shift;
  logic                        at_fall;
  logic                        at_midhigh;
  logic                        at_sample;
  logic                        take_bit;

  // bit clock, free running while a transfer is active
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n || state == st_idle) begin
      bit_cnt <= '0;
    end else begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  assign at_fall    = bit_cnt == '0;  // sclk falls on wrap
  assign at_midhigh = bit_cnt == `ADC5G_MIDHIGH;
  assign at_sample  = bit_cnt == sample_time;
  assign take_bit   = (state == st_read) && at_sample && (bit_idx != read_end);

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      state   <= st_idle;
      writing <= 1'b0;
      bit_idx <= '0;
      rdata   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state   <= st_clk_wait;
            writing <= cmd.addr[7];
          end
        end
        st_clk_wait: begin
          if (at_fall) begin
            state   <= st_addr;
            bit_idx <= '0;
          end
        end
        st_addr: begin
          if (at_fall) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == addr_last) begin
              state <= writing ? st_write : st_read_wait;
            end
          end
        end
        st_write: begin
          if (at_fall) begin
            bit_idx <= bit_idx + 1'b1;
          end
          if (at_midhigh && bit_idx == write_last) begin
            state <= st_almost_done;
          end
        end
        st_read_wait: begin
          if (at_fall) begin
            state <= st_read;  // ADC turns the data line around
          end
        end
        st_read: begin
          if (take_bit) begin
            bit_idx <= bit_idx + 1'b1;
          end
          if (at_midhigh && bit_idx == read_end) begin
            state <= st_almost_done;
          end
        end
        st_almost_done: begin
          if (at_sample) begin
            state <= st_finish;
          end
        end
        st_finish: begin
          if (at_fall) begin
            state <= st_idle;
            if (!writing) begin
              rdata <= rx_shift;
            end
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (state == st_idle && start) begin
      tx_shift <= cmd;
      rx_shift <= '0;
    end else begin
      if (at_fall && (state == st_addr || state == st_write)) begin
        tx_shift <= tx_shift << 1;
      end
      if (take_bit) begin
        rx_shift <= {rx_shift[14:0], sdo};  // MSB first
      end
    end
  end

  always_comb begin
    pins.sclk    = bit_cnt[4] && (state != st_read_wait) && (state != st_finish);
    pins.sdata   = tx_shift[$bits(spi_cmd_t)-1];
    pins.modepin = !(state == st_addr || state == st_write ||
                     state == st_read_wait || state == st_read);
  end

  assign idle = state == st_idle;

endmodule

`default_nettype wire

// File: design/adc5g_reset_gen.sv
// reset pulse restarts on every request, even mid-pulse; the unlocked count wraps at 16 bits
`timescale 1ns/1ns
`default_nettype none

`include "adc5g_defs.svh"

module adc5g_reset_gen (
  input  wire logic  OPB_Clk,
  input  wire logic  rst_n,
  input  wire logic  rst_req,
  input  wire logic  dcm_locked,
  output logic       adc_reset,
  output logic [15:0] unlocked_cnt
);

  logic [7:0] rst_cnt;

  // pulse length counter, loaded during system reset too
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      rst_cnt <= `ADC5G_RST_LEN;
    end else if (rst_req) begin
      rst_cnt <= `ADC5G_RST_LEN;
    end else if (rst_cnt != '0) begin
      rst_cnt <= rst_cnt - 1'b1;
    end
  end

  assign adc_reset = rst_cnt != '0;

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      unlocked_cnt <= '0;
    end else if (!dcm_locked) begin
      unlocked_cnt <= unlocked_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/adc5g_ctrl_top.sv
// single ADC channel; all logic runs on OPB_Clk and the ADC pins come straight from registers and state
`timescale 1ns/1ns
`default_nettype none

module adc5g_ctrl_top (
  input  wire logic                  OPB_Clk,
  input  wire logic                  rst_n,
  input  wire adc5g_wb_pkg::wb_req_t wb_req,
  input  wire logic                  adc_sdo,
  input  wire logic                  dcm_locked,
  output adc5g_wb_pkg::wb_data_t     wb_dat_o,
  output logic                       wb_ack,
  output adc5g_spi_pkg::spi_pins_t   adc_pins,
  output logic                       adc_reset
);
  import adc5g_spi_pkg::*;

  spi_cmd_t    spi_cmd;
  logic        spi_start;
  bit_time_t   sample_time;
  logic        spi_idle;
  spi_data_t   spi_rdata;
  logic        rst_req;
  logic [15:0] unlocked_cnt;

  adc5g_wb_regs adc5g_wb_regs_inst (
    .OPB_Clk      (OPB_Clk),
    .rst_n        (rst_n),
    .wb_req       (wb_req),
    .spi_idle     (spi_idle),
    .spi_rdata    (spi_rdata),
    .adc_reset    (adc_reset),
    .dcm_locked   (dcm_locked),
    .unlocked_cnt (unlocked_cnt),
    .wb_dat_o     (wb_dat_o),
    .wb_ack       (wb_ack),
    .spi_cmd      (spi_cmd),
    .spi_start    (spi_start),
    .sample_time  (sample_time),
    .rst_req      (rst_req)
  );

  adc5g_spi_master adc5g_spi_master_inst (
    .OPB_Clk     (OPB_Clk),
    .rst_n       (rst_n),
    .cmd         (spi_cmd),
    .start       (spi_start),
    .sample_time (sample_time),
    .sdo         (adc_sdo),
    .pins        (adc_pins),
    .idle        (spi_idle),
    .rdata       (spi_rdata)
  );

  adc5g_reset_gen adc5g_reset_gen_inst (
    .OPB_Clk      (OPB_Clk),
    .rst_n        (rst_n),
    .rst_req      (rst_req),
    .dcm_locked   (dcm_locked),
    .adc_reset    (adc_reset),
    .unlocked_cnt (unlocked_cnt)
  );

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
// free-running 4 ns clock; rst_n held low for 10 rising edges, released 1 ns after the last
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic OPB_Clk,
  output logic rst_n
);

  initial begin
    OPB_Clk = 1'b0;
    forever begin
      #2;
      OPB_Clk = ~OPB_Clk;
    end
  end

  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge OPB_Clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/adc5g_ctrl_tb.sv
// directed tests; bus driver and ADC model act 1 ns after each rising edge, run is capped at 1 ms
`timescale 1ns/1ns
`default_nettype none

module adc5g_ctrl_tb;
  import adc5g_wb_pkg::*;
  import adc5g_spi_pkg::*;

  localparam logic [31:0] addr_ctrl   = 32'h0;
  localparam logic [31:0] addr_spi    = 32'h4;
  localparam logic [31:0] addr_sample = 32'h8;
  localparam logic [31:0] addr_dcm    = 32'hc;
  localparam int          ack_timeout = 2000;
  localparam int          bit_cycles  = 32;

  logic      OPB_Clk;
  logic      rst_n;
  wb_req_t   wb_req;
  logic      adc_sdo;
  logic      dcm_locked;
  wb_data_t  wb_dat_o;
  logic      wb_ack;
  spi_pins_t adc_pins;
  logic      adc_reset;

  integer    seed;
  int        errors;
  int        test_errors;
  int        checks;

  logic [23:0] cap_word;  // ADC model state
  int          cap_count;
  spi_data_t   reply;
  int          reply_idx;
  logic        prev_sclk;
  logic        prev_mode;

  tb_clk_gen tb_clk_gen_inst (
    .OPB_Clk (OPB_Clk),
    .rst_n   (rst_n)
  );

  adc5g_ctrl_top adc5g_ctrl_top_inst (
    .OPB_Clk    (OPB_Clk),
    .rst_n      (rst_n),
    .wb_req     (wb_req),
    .adc_sdo    (adc_sdo),
    .dcm_locked (dcm_locked),
    .wb_dat_o   (wb_dat_o),
    .wb_ack     (wb_ack),
    .adc_pins   (adc_pins),
    .adc_reset  (adc_reset)
  );

  // after 8 address bits with bit 7 clear the ADC drives sdo
  function automatic logic read_phase();
    return (cap_count == 8) && !cap_word[7];
  endfunction

  initial begin
    adc_sdo   = 1'b0;
    prev_sclk = 1'b0;
    prev_mode = 1'b1;
    cap_word  = '0;
    cap_count = 0;
    reply_idx = 0;
    forever begin
      @(posedge OPB_Clk);
      #1;
      if (!adc_pins.modepin && prev_mode) begin  // new transfer
        cap_word  = '0;
        cap_count = 0;
        reply_idx = 0;
      end
      if (!adc_pins.modepin) begin
        if (adc_pins.sclk && !prev_sclk && !read_phase()) begin
          cap_word  = {cap_word[22:0], adc_pins.sdata};
          cap_count = cap_count + 1;
        end
        if (!adc_pins.sclk && prev_sclk && read_phase() && reply_idx < 16) begin
          adc_sdo   = reply[15 - reply_idx];  // MSB first
          reply_idx = reply_idx + 1;
        end
      end
      prev_sclk = adc_pins.sclk;
      prev_mode = adc_pins.modepin;
    end
  end

  task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic bus_cycle(input logic we, input logic [31:0] adr, input wb_data_t dat,
                           input wb_sel_t sel, output wb_data_t rdat, output int waited);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    waited = 0;
    rdat   = '0;
    do begin
      @(posedge OPB_Clk);
      #1;
      waited++;
    end while (!wb_ack && waited < ack_timeout);
    if (wb_ack) begin
      rdat = wb_dat_o;
    end else begin
      $display("no bus ack within %0d cycles for address 0x%0h", ack_timeout, adr);
      errors++;
      test_errors++;
    end
    wb_req = '0;  // host drops stb after ack
  endtask

  task automatic wb_write(input logic [31:0] adr, input wb_data_t dat, input wb_sel_t sel);
    wb_data_t rdat;
    int       waited;
    bus_cycle(1'b1, adr, dat, sel, rdat, waited);
  endtask

  task automatic wb_read(input logic [31:0] adr, output wb_data_t rdat, output int waited);
    bus_cycle(1'b0, adr, '0, 4'hf, rdat, waited);
  endtask

  task automatic wait_modepin(input logic level);
    int waited;
    waited = 0;
    while (adc_pins.modepin !== level && waited < ack_timeout) begin
      @(posedge OPB_Clk);
      #1;
      waited++;
    end
    if (adc_pins.modepin !== level) begin
      $display("modepin did not go to %0b within %0d cycles", level, ack_timeout);
      errors++;
      test_errors++;
    end
  endtask

  // counts edges after reset release that close a cycle with adc_reset high
  task automatic measure_reset_pulse(output int cycles);
    logic high_before;
    logic done;
    int   waited;
    cycles      = 0;
    waited      = 0;
    done        = 1'b0;
    high_before = adc_reset;
    while (!done && waited < 200) begin
      @(posedge OPB_Clk);
      if (rst_n && high_before) begin
        cycles++;
      end else if (rst_n && cycles > 0) begin
        done = 1'b1;
      end
      #1;
      high_before = adc_reset;
      waited++;
    end
    if (!done) begin
      $display("adc_reset pulse did not end within 200 cycles");
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    if (test_errors == 0) begin
      $display("test %s passed", name);
    end else begin
      $display("test %s failed with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  // starts a read command and reads the SPI word, which stalls until the engine is idle
  task automatic serial_read(input spi_addr_t addr, output wb_data_t rdat, output int waited);
    wb_write(addr_spi, {16'h0, addr, 8'h01}, 4'hf);
    wb_read(addr_spi, rdat, waited);
  endtask

  task automatic reset_defaults();
    int       cycles;
    int       waited;
    wb_data_t rdat;
    measure_reset_pulse(cycles);
    check_equal("adc_reset cycles after rst_n", cycles, 16);
    wb_read(addr_ctrl, rdat, waited);
    check_equal("CTRL bit 0", rdat[0], 1'b0);
    wb_read(addr_sample, rdat, waited);
    check_equal("SAMPLE", rdat[4:0], 5'd13);
    wb_read(addr_spi, rdat, waited);
    check_equal("SPI idle bit", rdat[0], 1'b1);
    check_equal("modepin", adc_pins.modepin, 1'b1);
    check_equal("sclk", adc_pins.sclk, 1'b0);
    report_test("reset_defaults");
  endtask

  task automatic serial_write();
    spi_addr_t addr;
    spi_data_t data;
    wb_data_t  rdat;
    int        waited;
    addr = 8'hc6;  // bit 7 set, write
    data = 16'h5a3c;
    wb_write(addr_spi, {data, addr, 8'h01}, 4'hf);
    wait_modepin(1'b0);
    wait_modepin(1'b1);
    check_equal("captured bit count", cap_count, 24);
    check_equal("captured write word", cap_word, {addr, data});
    wb_read(addr_spi, rdat, waited);
    check_equal("SPI idle bit", rdat[0], 1'b1);
    check_equal("SPI stored address", rdat[15:8], addr);
    report_test("serial_write");
  endtask

  task automatic serial_read_stall();
    logic [31:0] rnd;
    wb_data_t    rdat;
    int          waited;
    rnd   = $random(seed);
    reply = rnd[15:0];
    serial_read(8'h2b, rdat, waited);
    checks++;
    assert (waited > 24 * bit_cycles) else begin
      $display("[ERROR] %0t ns: SPI read acked after %0d cycles, engine still busy", $time, waited);
      errors++;
      test_errors++;
    end
    check_equal("modepin at stalled ack", adc_pins.modepin, 1'b1);
    check_equal("read data", rdat[31:16], reply);
    check_equal("SPI idle bit", rdat[0], 1'b1);
    check_equal("captured address bits", cap_count, 8);
    check_equal("captured address", cap_word[7:0], 8'h2b);
    report_test("serial_read_stall");
  endtask

  task automatic sample_byte_select();
    logic [31:0] rnd;
    wb_data_t    rdat;
    int          waited;
    wb_write(addr_sample, 32'h0000_0007, 4'b1110);
    wb_read(addr_sample, rdat, waited);
    check_equal("SAMPLE with sel 0 low", rdat[4:0], 5'd13);
    wb_write(addr_sample, 32'h0000_0014, 4'hf);
    wb_read(addr_sample, rdat, waited);
    check_equal("SAMPLE with sel 0 high", rdat[4:0], 5'd20);
    rnd   = $random(seed);
    reply = rnd[15:0];
    serial_read(8'h11, rdat, waited);
    check_equal("read data at sample 20", rdat[31:16], reply);
    report_test("sample_byte_select");
  endtask

  task automatic software_reset();
    int       cycles;
    int       waited;
    wb_data_t rdat;
    wb_write(addr_ctrl, 32'h1, 4'hf);
    measure_reset_pulse(cycles);
    check_equal("adc_reset cycles after request", cycles, 16);
    wb_read(addr_ctrl, rdat, waited);
    check_equal("CTRL bit 0 after pulse", rdat[0], 1'b0);
    wb_write(addr_ctrl, 32'h1, 4'hf);
    wb_read(addr_ctrl, rdat, waited);
    check_equal("CTRL bit 0 during pulse", rdat[0], 1'b1);
    measure_reset_pulse(cycles);  // second pulse only has to run out
    report_test("software_reset");
  endtask

  task automatic unlocked_count();
    wb_data_t rdat;
    int       waited;
    int       low_cycles;
    wb_read(addr_dcm, rdat, waited);
    check_equal("unlocked count before", rdat[15:0], 16'd0);
    dcm_locked = 1'b0;
    repeat (37) @(posedge OPB_Clk);
    #1;
    wb_read(addr_dcm, rdat, waited);  // word captured one edge before ack
    check_equal("lock bit while unlocked", rdat[16], 1'b0);
    check_equal("unlocked count while unlocked", rdat[15:0], 37 + waited - 1);
    low_cycles = 37 + waited;
    dcm_locked = 1'b1;
    wb_read(addr_dcm, rdat, waited);
    check_equal("unlocked count", rdat[15:0], low_cycles);
    check_equal("lock bit", rdat[16], 1'b1);
    report_test("unlocked_count");
  endtask

  initial begin
    wb_req      = '0;
    dcm_locked  = 1'b1;
    seed        = 32'hfe126a69;
    errors      = 0;
    test_errors = 0;
    checks      = 0;
    reply       = '0;
    reset_defaults();
    serial_write();
    serial_read_stall();
    sample_byte_select();
    software_reset();
    unlocked_count();
    $display("tests run: 6, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #1_000_000;
    $display("simulation time limit reached, a test is hung");
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/adc5g_wb_pkg.sv
common/adc5g_spi_pkg.sv
design/adc5g_wb_regs.sv
spi/adc5g_spi_master.sv
design/adc5g_reset_gen.sv
design/adc5g_ctrl_top.sv
dv/tb_clk_gen.sv
dv/adc5g_ctrl_tb.sv
